// File: hdl/fetchPkg.sv
package fetchPkg;

	// memory response status
	typedef enum logic [1:0]
	{
		okReady = 2'd0,	// idle, takes a request
		okHold = 2'd1,	// request in progress
		okDone = 2'd2	// data valid this cycle
	} memOk;

	// cache memory operation
	typedef enum logic [4:0]
	{
		opmReady = 5'h00,	// no request
		opmReadTile = 5'h01	// one 128-bit tile
	} memOpm;

	localparam int pcWidth = 32;
	localparam int tileBits = 128;
	localparam int windowBits = 64;

	// cache geometry, per bank
	localparam int lineCount = 64;
	localparam int indexBits = $clog2(lineCount);
	localparam int tileAddrBits = pcWidth - 4;	// pc bits above the tile offset
	localparam int tagBits = tileAddrBits - indexBits;

	// backing store, 64 KiB
	localparam int tileWords = 4096;
	localparam int tileIndexBits = $clog2(tileWords);

	localparam int tileLatency = 3;	// okHold cycles before okDone
	localparam int holdCountBits = $clog2(tileLatency);

endpackage

// File: hdl/memTileIf.sv
interface memTileIf import fetchPkg::*; ();

	logic [pcWidth-1:0] addr;	// tile aligned
	memOpm opm;
	logic [tileBits-1:0] data;
	memOk ok;

	modport cache
	(
		output addr,
		output opm,
		input data,
		input ok
	);

	modport memory
	(
		input addr,
		input opm,
		output data,
		output ok
	);

endinterface

// File: hdl/instCache.sv
module instCache import fetchPkg::*;
(
	input logic clock,
	input logic reset,
	input logic [pcWidth-1:0] lookupPc,
	output logic [windowBits-1:0] window,
	output logic windowValid,
	output logic [1:0] step,
	memTileIf.cache mem
);

	typedef enum logic [1:0]
	{
		fillIdle,
		fillRead,
		fillWait
	} fillPhase;

	// index 0 is the even bank, 1 the odd bank
	logic [63:0] bankData [2][lineCount];
	logic [tagBits-1:0] bankTag [2][lineCount];
	logic [lineCount-1:0] bankValid [2];

	logic [tileAddrBits-1:0] nextTile [2];

	// registered lookup
	logic lookupLive;
	logic [2:0] reqOffset;	// pc[3:1]
	logic [tileAddrBits-1:0] reqTile [2];
	logic [63:0] blkData [2];
	logic [tagBits-1:0] blkTag [2];
	logic [1:0] blkValid;

	logic [1:0] miss;
	logic [tileBits-1:0] block;

	fillPhase phase;
	logic [tileAddrBits-1:0] fillTile;
	logic [indexBits-1:0] fillIndex;
	logic [tagBits-1:0] fillTag;
	logic fillWrite;

	function automatic logic [1:0] lengthOf(input logic [15:0] word);
		logic [1:0] len;
		casez (word[15:10])
			6'b111?11: len = 2'd3;
			6'b111?10, 6'b111?01, 6'b111?00: len = 2'd2;
			default: len = 2'd1;
		endcase
		return len;
	endfunction

	// odd half is always the current tile
	always_comb
	begin
		nextTile[1] = lookupPc[pcWidth-1:4];
		nextTile[0] = lookupPc[3] ? nextTile[1] + tileAddrBits'(1) : nextTile[1];
	end

	always_ff @(posedge clock)
	begin
		for (int b = 0; b < 2; b++)
		begin
			if (fillWrite)
			begin
				bankData[b][fillIndex] <= mem.data[64*b +: 64];	// low half to even
				bankTag[b][fillIndex] <= fillTag;
			end
			blkData[b] <= bankData[b][nextTile[b][indexBits-1:0]];
			blkTag[b] <= bankTag[b][nextTile[b][indexBits-1:0]];
			reqTile[b] <= nextTile[b];
		end
		reqOffset <= lookupPc[3:1];
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int b = 0; b < 2; b++)
				bankValid[b] <= '0;
			blkValid <= 2'b00;
			lookupLive <= 1'b0;
		end
		else
		begin
			for (int b = 0; b < 2; b++)
			begin
				if (fillWrite)
					bankValid[b][fillIndex] <= 1'b1;
				blkValid[b] <= bankValid[b][nextTile[b][indexBits-1:0]];
			end
			lookupLive <= 1'b1;
		end
	end

	always_comb
	begin
		for (int b = 0; b < 2; b++)
			miss[b] = !blkValid[b] || blkTag[b] != reqTile[b][tileAddrBits-1:indexBits];
	end

	// pc[3] set puts the odd half first
	always_comb
	begin
		block = reqOffset[2] ? {blkData[0], blkData[1]} : {blkData[1], blkData[0]};
		window = block[{reqOffset[1:0], 4'b0000} +: windowBits];
	end

	assign step = lengthOf(window[15:0]);
	assign windowValid = lookupLive && miss == 2'b00;

	// miss handling, one tile at a time
	always_ff @(posedge clock)
	begin
		if (reset)
			phase <= fillIdle;
		else
		begin
			case (phase)
				fillIdle:
				begin
					if (lookupLive && miss != 2'b00 && mem.ok == okReady)
						phase <= fillRead;
				end
				fillRead:
				begin
					if (mem.ok == okDone)
						phase <= fillWait;
				end
				default:
				begin
					// fresh lookup lands while memory goes back to ready
					if (mem.ok == okReady)
						phase <= fillIdle;
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (phase == fillIdle)
			fillTile <= miss[0] ? reqTile[0] : reqTile[1];	// even bank first
	end

	assign fillIndex = fillTile[indexBits-1:0];
	assign fillTag = fillTile[tileAddrBits-1:indexBits];
	assign fillWrite = phase == fillRead && mem.ok == okDone;

	assign mem.addr = {fillTile, 4'b0000};
	assign mem.opm = (phase == fillRead && mem.ok != okDone) ? opmReadTile : opmReady;

	// a new request only starts on an idle bus
	assert property (@(posedge clock) disable iff (reset)
		mem.opm == opmReadTile && $past(mem.opm) != opmReadTile |-> mem.ok == okReady);

	assert property (@(posedge clock) disable iff (reset)
		mem.ok == okHold |-> $stable(mem.opm) && $stable(mem.addr));

endmodule

// File: hdl/tileMemory.sv
module tileMemory import fetchPkg::*;
(
	input logic clock,
	input logic reset,
	input logic loadEnable,
	input logic [tileIndexBits-1:0] loadIndex,
	input logic [tileBits-1:0] loadTile,
	memTileIf.memory mem
);

	typedef enum logic [1:0]
	{
		memIdle,
		memBusy,
		memDone
	} memState;

	logic [tileBits-1:0] tiles [tileWords];

	memState state;
	logic [holdCountBits-1:0] holdCount;
	logic lastHold;
	logic [tileIndexBits-1:0] readIndex;
	logic [tileBits-1:0] readData;

	assign lastHold = holdCount == holdCountBits'(tileLatency - 1);

	// preload port
	always_ff @(posedge clock)
	begin
		if (loadEnable)
			tiles[loadIndex] <= loadTile;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= memIdle;
			holdCount <= '0;
		end
		else
		begin
			case (state)
				memIdle:
				begin
					holdCount <= '0;
					if (mem.opm == opmReadTile)
						state <= memBusy;
				end
				memBusy:
				begin
					holdCount <= holdCount + holdCountBits'(1);
					if (lastHold)
						state <= memDone;
				end
				default:
				begin
					if (mem.opm == opmReady)
						state <= memIdle;
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == memIdle && mem.opm == opmReadTile)
			readIndex <= mem.addr[tileIndexBits+3:4];
		if (state == memBusy && lastHold)
			readData <= tiles[readIndex];
	end

	always_comb
	begin
		case (state)
			memBusy: mem.ok = okHold;
			memDone: mem.ok = okDone;
			default: mem.ok = okReady;
		endcase
	end

	assign mem.data = readData;

	// the cache drops its request as soon as it sees okDone
	assert property (@(posedge clock) disable iff (reset)
		state == memDone |-> mem.opm != opmReadTile);

endmodule

// File: hdl/fetchUnit.sv
module fetchUnit import fetchPkg::*;
(
	input logic clock,
	input logic reset,
	input logic redirect,
	input logic [pcWidth-1:0] redirectPc,
	input logic windowValid,
	input logic [1:0] step,
	output logic [pcWidth-1:0] lookupPc,
	output logic [pcWidth-1:0] fetchPc,
	output logic fetchValid
);

	logic started;	// first redirect seen

	assign fetchValid = windowValid && started;

	// next address for the cache
	always_comb
	begin
		if (redirect)
			lookupPc = redirectPc;
		else if (fetchValid)
			lookupPc = fetchPc + pcWidth'({step, 1'b0});	// step in halfwords
		else
			lookupPc = fetchPc;	// hold on miss
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			fetchPc <= '0;
			started <= 1'b0;
		end
		else
		begin
			fetchPc <= lookupPc;
			if (redirect)
				started <= 1'b1;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		windowValid |-> step != 2'd0);

endmodule

// File: hdl/fetchTop.sv
module fetchTop import fetchPkg::*;
(
	input logic clock,
	input logic reset,
	input logic redirect,
	input logic [pcWidth-1:0] redirectPc,
	input logic loadEnable,
	input logic [tileIndexBits-1:0] loadIndex,
	input logic [tileBits-1:0] loadTile,
	output logic [pcWidth-1:0] fetchPc,
	output logic [windowBits-1:0] fetchWindow,
	output logic [1:0] fetchStep,
	output logic fetchValid
);

	memTileIf memBus ();

	logic [pcWidth-1:0] lookupPc;
	logic windowValid;

	fetchUnit unit0
	(
		.clock(clock),
		.reset(reset),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.windowValid(windowValid),
		.step(fetchStep),
		.lookupPc(lookupPc),
		.fetchPc(fetchPc),
		.fetchValid(fetchValid)
	);

	instCache cache0
	(
		.clock(clock),
		.reset(reset),
		.lookupPc(lookupPc),
		.window(fetchWindow),
		.windowValid(windowValid),
		.step(fetchStep),
		.mem(memBus.cache)
	);

	tileMemory memory0
	(
		.clock(clock),
		.reset(reset),
		.loadEnable(loadEnable),
		.loadIndex(loadIndex),
		.loadTile(loadTile),
		.mem(memBus.memory)
	);

endmodule

// File: tb/clockGen.sv
module clockGen
(
	output logic clock,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ns;

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;	// 100 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

// File: tb/fetchTb.sv
module fetchTb import fetchPkg::*;
();

	timeunit 1ns;
	timeprecision 1ns;

	localparam int timeoutCycles = 200;

	logic clock;
	logic reset;
	logic redirect;
	logic [pcWidth-1:0] redirectPc;
	logic loadEnable;
	logic [tileIndexBits-1:0] loadIndex;
	logic [tileBits-1:0] loadTile;
	logic [pcWidth-1:0] fetchPc;
	logic [windowBits-1:0] fetchWindow;
	logic [1:0] fetchStep;
	logic fetchValid;

	logic [tileBits-1:0] image [tileWords];	// reference copy of memory
	logic [tileIndexBits-1:0] loadOrder [$];
	logic [pcWidth-1:0] runPc [$];
	int runCount [$];

	clockGen clockGen0
	(
		.clock(clock),
		.reset(reset)
	);

	fetchTop dut0
	(
		.clock(clock),
		.reset(reset),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.loadEnable(loadEnable),
		.loadIndex(loadIndex),
		.loadTile(loadTile),
		.fetchPc(fetchPc),
		.fetchWindow(fetchWindow),
		.fetchStep(fetchStep),
		.fetchValid(fetchValid)
	);

	task automatic stopOnError();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic logic [15:0] halfwordAt(input logic [pcWidth-1:0] byteAddr);
		logic [tileBits-1:0] tile;
		tile = image[byteAddr[15:4]];
		return tile[{byteAddr[3:1], 4'b0000} +: 16];
	endfunction

	// four halfwords in address order, first one in the low bits
	function automatic logic [windowBits-1:0] expectedWindow(input logic [pcWidth-1:0] pc);
		logic [windowBits-1:0] win;
		for (int i = 0; i < 4; i++)
			win[16*i +: 16] = halfwordAt(pc + pcWidth'(2 * i));
		return win;
	endfunction

	function automatic logic [1:0] expectedStep(input logic [15:0] word);
		if (word[15:13] != 3'b111)
			return 2'd1;
		if (word[11:10] == 2'b11)
			return 2'd3;
		return 2'd2;
	endfunction

	task automatic checkWindow(input logic [windowBits-1:0] expWindow,
		input logic [pcWidth-1:0] expPc);
		if (fetchPc !== expPc)
		begin
			$display("FAIL fetchPc expected %h actual %h", expPc, fetchPc);
			stopOnError();
		end
		if (fetchWindow !== expWindow)
		begin
			$display("FAIL fetchWindow at pc %h expected %h actual %h",
				expPc, expWindow, fetchWindow);
			stopOnError();
		end
	endtask

	task automatic checkStep(input logic [1:0] expStep);
		if (fetchStep !== expStep)
		begin
			$display("FAIL fetchStep at pc %h expected %h actual %h", fetchPc, expStep, fetchStep);
			stopOnError();
		end
	endtask

	task automatic readVectors();
		int fd;
		int fields;
		string line;
		logic [tileIndexBits-1:0] index;
		logic [tileBits-1:0] tile;
		logic [pcWidth-1:0] pc;
		int count;
		fd = $fopen("tb/fetchVectors.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the vector file tb/fetchVectors.txt");
			stopOnError();
		end
		while ($fgets(line, fd) != 0)
		begin
			fields = 0;
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			if (line.getc(0) == "T")
			begin
				fields = $sscanf(line, "T %h %h", index, tile);
				image[index] = tile;
				loadOrder.push_back(index);
			end
			else if (line.getc(0) == "R")
			begin
				fields = $sscanf(line, "R %h %d", pc, count);
				runPc.push_back(pc);
				runCount.push_back(count);
			end
			if (fields != 2)
			begin
				$display("malformed line in the vector file: %s", line);
				stopOnError();
			end
		end
		$fclose(fd);
	endtask

	task automatic preloadTiles();
		foreach (loadOrder[i])
		begin
			@(posedge clock);
			loadEnable <= 1'b1;
			loadIndex <= loadOrder[i];
			loadTile <= image[loadOrder[i]];
		end
		@(posedge clock);
		loadEnable <= 1'b0;
	endtask

	task automatic waitResetDone();
		int cycles;
		cycles = 0;
		while (reset)
		begin
			@(posedge clock);
			cycles++;
			if (cycles > timeoutCycles)
			begin
				$display("reset never went low");
				stopOnError();
			end
		end
	endtask

	task automatic waitFetchValid(input logic [pcWidth-1:0] pc);
		int cycles;
		cycles = 0;
		@(negedge clock);	// outputs settled mid cycle
		while (!fetchValid)
		begin
			cycles++;
			if (cycles > timeoutCycles)
			begin
				$display("no valid fetch window for pc %h within %0d cycles", pc, timeoutCycles);
				stopOnError();
			end
			@(negedge clock);
		end
	endtask

	task automatic runFetches(input logic [pcWidth-1:0] startPc, input int count);
		logic [pcWidth-1:0] pc;
		logic [windowBits-1:0] expWindow;
		logic [1:0] expStep;
		@(posedge clock);
		redirect <= 1'b1;
		redirectPc <= startPc;
		@(posedge clock);
		redirect <= 1'b0;
		pc = startPc;
		for (int i = 0; i < count; i++)
		begin
			waitFetchValid(pc);
			expWindow = expectedWindow(pc);
			expStep = expectedStep(expWindow[15:0]);
			checkWindow(expWindow, pc);
			checkStep(expStep);
			pc = pc + pcWidth'({expStep, 1'b0});	// step counts halfwords
		end
	endtask

	initial
	begin
		int gap;
		redirect = 1'b0;
		redirectPc = '0;
		loadEnable = 1'b0;
		loadIndex = '0;
		loadTile = '0;
		void'($urandom(32'hb32f_c2e1));
		readVectors();
		preloadTiles();	// overlaps reset, tile 0 goes first
		waitResetDone();
		foreach (runPc[i])
		begin
			gap = $urandom_range(3, 0);
			repeat (gap) @(posedge clock);
			runFetches(runPc[i], runCount[i]);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

// File: tb/fetchVectors.txt
# T <tile index hex> <128-bit tile hex, halfword 0 rightmost>
# R <start pc hex> <number of fetch windows, decimal>
# tile 0 first, the cache fills it right after reset
T 000 0000000000000000000000000000C0DE
# stream at 0x100 with every length pattern at an instruction start
T 010 E0006666E4004444E80022221111EC00
T 011 F400BBBBF800AAAA9999FC0012348888
T 012 765432100DEF0ABCD000DDDDF000CCCC
T 013 13571357246824680F0F0F0F5A5A5A5A
T 014 00010002000300040005000600070008
# fresh pair, 0x20E misses in both banks
T 020 EC00F0001234E40056789ABCDEF00123
T 021 0246E8001357F4002468ACE0FC001111
T 022 3C3C4D4D5E5EE0006F6F7A7A8B8B9C9C
T 023 00FF00FF00FF00FF00FF00FF00FF00FF
# same cache index as tile 020
T 060 A1A2B1B2C1C2D1D2E1E2F1F2EC00F400
T 061 1010202030304040505060607070F800
T 062 11223344556677889900AABBCCDDEEFF
R 100 14
R 20E 6
R 226 4
R 600 4
R 60E 3
R 10E 3
R 106 2
# earlier start points again
R 100 14
R 20E 6

// File: verilog.f
hdl/fetchPkg.sv
hdl/memTileIf.sv
hdl/instCache.sv
hdl/tileMemory.sv
hdl/fetchUnit.sv
hdl/fetchTop.sv
tb/clockGen.sv
tb/fetchTb.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module fetchTb

output=$(./obj_dir/VfetchTb || true)
echo "$output"

if echo "$output" | grep -q "TEST OK"; then
	exit 0
else
	exit 1
fi
